// ==== hw/uart_cfg.svh ====
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// bus side
`define UART_BASE_ADDR 16'hFF16   // address of register 0
`define UART_ADDR_W 16            // system bus address width

// serial side, 8N1 at a fixed rate
`define UART_CLK_FREQ 1000000     // system clock in Hz
`define UART_BAUD 9600

// clocks per serial bit, 104 at the values above
`define UART_BIT_CYCLES (`UART_CLK_FREQ / `UART_BAUD)

`endif

// ==== hw/uart_pkg.sv ====
`include "uart_cfg.svh"

package uart_pkg;

    typedef logic [`UART_ADDR_W-1:0] bus_addr_t;   // system bus address
    typedef logic [7:0] byte_t;                    // bus data and serial payload
    typedef logic [1:0] reg_offset_t;              // register inside the window
    typedef logic [3:0] bit_cnt_t;                 // counts up to 8 data bits

    // transmitter frame sequence
    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_t;

    // receiver frame sequence
    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

endpackage

// ==== hw/baud_tick_gen.sv ====
`timescale 1ns/100ps
`include "uart_cfg.svh"

module baud_tick_gen (
    input  logic clk,
    input  logic reset,
    output logic tick
);

    localparam int cnt_w = $clog2(`UART_BIT_CYCLES);
    localparam logic [cnt_w-1:0] cnt_max = cnt_w'(`UART_BIT_CYCLES - 1);

    logic [cnt_w-1:0] count;
    logic             wrap;

    assign wrap = (count == cnt_max);

    // free running, never stopped once out of reset
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            count <= '0;
            tick  <= 1'b0;
        end
        else
        begin
            count <= wrap ? '0 : count + 1'b1;
            tick  <= wrap;  // one clock wide
        end
    end

endmodule

// ==== hw/uart_tx.sv ====
`timescale 1ns/100ps

module uart_tx (
    input  logic           clk,
    input  logic           reset,
    input  logic           tick,
    input  uart_pkg::byte_t tx_byte,
    input  logic           tx_start,
    output logic           tx,
    output logic           tx_done
);

    import uart_pkg::*;

    tx_state_t state;
    bit_cnt_t  bit_cnt;   // data bits already on the line
    byte_t     shift;

    // byte copy, reloaded on every idle tick so the frame start takes a fresh value
    always_ff @(posedge clk)
    begin
        if (tick)
        begin
            if (state == tx_idle)
                shift <= tx_byte;
            else
                shift <= shift >> 1;  // lsb first
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state   <= tx_idle;
            bit_cnt <= '0;
            tx      <= 1'b1;
            tx_done <= 1'b0;
        end
        else
        begin
            tx_done <= 1'b0;
            if (tick)
            begin
                case (state)
                    tx_idle:
                    begin
                        if (tx_start)
                        begin
                            tx    <= 1'b0;  // start bit
                            state <= uart_pkg::tx_start;
                        end
                    end
                    uart_pkg::tx_start:
                    begin
                        tx      <= shift[0];
                        bit_cnt <= bit_cnt_t'(1);
                        state   <= tx_data;
                    end
                    tx_data:
                    begin
                        if (bit_cnt == bit_cnt_t'(8))
                        begin
                            tx    <= 1'b1;  // stop bit
                            state <= tx_stop;
                        end
                        else
                        begin
                            tx      <= shift[0];
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    tx_stop:
                    begin
                        tx_done <= 1'b1;  // end of stop bit
                        state   <= tx_idle;
                    end
                    default: state <= tx_idle;
                endcase
            end
        end
    end

endmodule

// ==== hw/uart_rx.sv ====
`timescale 1ns/100ps
`include "uart_cfg.svh"

module uart_rx (
    input  logic            clk,
    input  logic            reset,
    input  logic            rx,
    output uart_pkg::byte_t rx_byte,
    output logic            rx_valid
);

    import uart_pkg::*;

    localparam int cnt_w = $clog2(`UART_BIT_CYCLES);
    localparam logic [cnt_w-1:0] half_max = cnt_w'(`UART_BIT_CYCLES / 2 - 1);
    localparam logic [cnt_w-1:0] bit_max = cnt_w'(`UART_BIT_CYCLES - 1);

    logic rx_meta;
    logic rx_sync;
    logic rx_last;   // previous synchronized value, for the start edge
    logic fall;
    logic sample;

    rx_state_t        state;
    logic [cnt_w-1:0] count;   // own bit timer, restarted at the start edge
    bit_cnt_t         bit_cnt;
    byte_t            shift;

    // two-flop synchronizer, idle level is high
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
        end
        else
        begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;
        end
    end

    assign fall   = rx_last & ~rx_sync;
    assign sample = (count == bit_max);  // middle of data and stop bits

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state    <= rx_idle;
            count    <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end
        else
        begin
            rx_valid <= 1'b0;
            case (state)
                rx_idle:
                begin
                    count <= '0;
                    if (fall)
                        state <= rx_start;
                end
                rx_start:
                begin
                    if (count == half_max)
                    begin
                        count   <= '0;
                        bit_cnt <= '0;
                        state   <= rx_sync ? rx_idle : rx_data;  // glitch, not a start bit
                    end
                    else
                        count <= count + 1'b1;
                end
                rx_data:
                begin
                    if (sample)
                    begin
                        count   <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == bit_cnt_t'(7))
                            state <= rx_stop;
                    end
                    else
                        count <= count + 1'b1;
                end
                rx_stop:
                begin
                    if (sample)
                    begin
                        count    <= '0;
                        rx_valid <= rx_sync;  // low stop bit drops the byte
                        state    <= rx_idle;
                    end
                    else
                        count <= count + 1'b1;
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // byte assembly, lsb arrives first
    always_ff @(posedge clk)
    begin
        if (state == rx_data && sample)
            shift <= {rx_sync, shift[7:1]};
        if (state == rx_stop && sample && rx_sync)
            rx_byte <= shift;
    end

endmodule

// ==== hw/uart_regs.sv ====
`timescale 1ns/100ps
`include "uart_cfg.svh"

module uart_regs (
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    input  logic                write_en,
    input  uart_pkg::bus_addr_t addr,
    input  uart_pkg::byte_t     data_in,
    output uart_pkg::byte_t     data_out,
    output uart_pkg::byte_t     tx_byte,
    output logic                tx_start,
    input  logic                tx_done,
    input  uart_pkg::byte_t     rx_byte,
    input  logic                rx_valid,
    output logic                interrupt
);

    import uart_pkg::*;

    localparam bus_addr_t base_addr = bus_addr_t'(`UART_BASE_ADDR);
    localparam bus_addr_t last_addr = base_addr + bus_addr_t'(3);

    logic        hit;
    logic        wr;
    reg_offset_t offset;

    byte_t tx_cmd_reg;     // 0 requests a frame
    byte_t tx_data_reg;
    byte_t rx_status_reg;  // 1 when a byte is waiting
    byte_t rx_data_reg;
    logic  rx_valid_d;

    byte_t rd_tx_cmd;
    byte_t rd_tx_data;
    byte_t rd_rx_status;
    byte_t rd_rx_data;

    // four-byte window decode
    assign hit    = enable && (addr >= base_addr) && (addr <= last_addr);
    assign offset = reg_offset_t'(addr - base_addr);
    assign wr     = hit && write_en;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            tx_cmd_reg    <= 8'd1;
            tx_data_reg   <= '0;
            rx_status_reg <= '0;
            rx_data_reg   <= '0;
        end
        else
        begin
            // hardware events take priority over the bus
            if (tx_done)
                tx_cmd_reg <= 8'd1;
            else if (wr && offset == reg_offset_t'(0))
                tx_cmd_reg <= data_in;

            if (wr && offset == reg_offset_t'(1))
                tx_data_reg <= data_in;

            if (rx_valid)
                rx_status_reg <= 8'd1;
            else if (wr && offset == reg_offset_t'(2))
                rx_status_reg <= data_in;  // software clears with 0

            if (rx_valid)
                rx_data_reg <= rx_byte;  // newer byte always overwrites
        end
    end

    assign tx_byte  = tx_data_reg;
    assign tx_start = (tx_cmd_reg == '0);

    // one-cycle pulse, a register behind rx_valid
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            rx_valid_d <= 1'b0;
            interrupt  <= 1'b0;
        end
        else
        begin
            rx_valid_d <= rx_valid;
            interrupt  <= rx_valid & ~rx_valid_d;
        end
    end

    // readback, only the selected register is nonzero
    assign rd_tx_cmd    = (hit && offset == reg_offset_t'(0)) ? tx_cmd_reg : '0;
    assign rd_tx_data   = (hit && offset == reg_offset_t'(1)) ? tx_data_reg : '0;
    assign rd_rx_status = (hit && offset == reg_offset_t'(2)) ? rx_status_reg : '0;
    assign rd_rx_data   = (hit && offset == reg_offset_t'(3)) ? rx_data_reg : '0;

    assign data_out = rd_tx_cmd | rd_tx_data | rd_rx_status | rd_rx_data;

endmodule

// ==== hw/uart_periph.sv ====
`timescale 1ns/100ps

module uart_periph (
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    input  logic                write_en,
    input  uart_pkg::bus_addr_t addr,
    input  uart_pkg::byte_t     data_in,
    output uart_pkg::byte_t     data_out,
    output logic                interrupt,
    input  logic                rx,
    output logic                tx
);

    import uart_pkg::*;

    logic  tick;       // one clock per bit period
    byte_t tx_byte;
    logic  tx_start;
    logic  tx_done;
    byte_t rx_byte;
    logic  rx_valid;

    uart_regs u_regs (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .write_en  (write_en),
        .addr      (addr),
        .data_in   (data_in),
        .data_out  (data_out),
        .tx_byte   (tx_byte),
        .tx_start  (tx_start),
        .tx_done   (tx_done),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid),
        .interrupt (interrupt)
    );

    baud_tick_gen u_baud (
        .clk   (clk),
        .reset (reset),
        .tick  (tick)
    );

    uart_tx u_tx (
        .clk      (clk),
        .reset    (reset),
        .tick     (tick),
        .tx_byte  (tx_byte),
        .tx_start (tx_start),
        .tx       (tx),
        .tx_done  (tx_done)
    );

    // receiver keeps its own timing, no shared tick
    uart_rx u_rx (
        .clk      (clk),
        .reset    (reset),
        .rx       (rx),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

endmodule

// ==== dv/uart_assertions.sv ====
`timescale 1ns/100ps

module uart_assertions (
    input logic            clk,
    input logic            reset,
    input logic            enable,
    input logic            interrupt,
    input logic            tx,
    input uart_pkg::byte_t data_out
);

    // single-cycle pulse per received byte
    irq_one_cycle: assert property (
        @(posedge clk) disable iff (!reset) interrupt |=> !interrupt
    ) else $error("interrupt high for two consecutive cycles");

    // line idles high while held in reset
    tx_high_in_reset: assert property (
        @(posedge clk) !reset |=> tx
    ) else $error("tx low during reset");

    data_out_zero_when_disabled: assert property (
        @(posedge clk) !enable |-> (data_out == '0)   // readback is gated by the hit
    ) else $error("data_out nonzero with enable low");

endmodule

bind uart_periph uart_assertions u_assertions (
    .clk       (clk),
    .reset     (reset),
    .enable    (enable),
    .interrupt (interrupt),
    .tx        (tx),
    .data_out  (data_out)
);

// ==== dv/uart_tb.sv ====
`timescale 1ns/100ps
`include "uart_cfg.svh"

module uart_tb;

    import uart_pkg::*;

    typedef enum logic [2:0] {
        op_idle, op_write, op_read, op_send, op_send_bad, op_expect_tx, op_duplex
    } op_t;

    typedef enum logic [1:0] {src_lit, src_rx_rnd, src_tx_rnd} src_t;

    typedef struct packed {
        logic [2:0] test;
        op_t        op;
        logic       en;     // bus enable during the access
        bus_addr_t  addr;
        src_t       src;    // literal or one of the random bytes
        byte_t      value;
    } row_t;

    localparam int        bit_cycles = `UART_BIT_CYCLES;
    localparam bus_addr_t base_addr = `UART_BASE_ADDR;

    logic      clk;
    logic      reset;
    logic      enable;
    logic      write_en;
    bus_addr_t addr;
    byte_t     data_in;
    byte_t     data_out;
    logic      interrupt;
    logic      rx;
    logic      tx;

    row_t        rows[$];
    string       test_names[6] = '{"reset state", "transmit", "receive", "address decode",
                                   "full duplex", "bad frame"};
    logic [16:0] lfsr = 17'd71605;
    byte_t       rnd_rx;   // last byte sent on rx
    byte_t       rnd_tx;   // last byte written to tx_data
    int          checks = 0;
    int          errors = 0;
    int          test_checks = 0;
    int          test_errors = 0;
    int          irq_pulses = 0;
    int          irq_cycles = 0;
    int          pulses_before = 0;
    int          cycles_before = 0;
    logic        irq_last = 1'b0;
    int          cycle_count = 0;
    int          timeout_limit = 0;

    uart_periph u_dut (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .write_en  (write_en),
        .addr      (addr),
        .data_in   (data_in),
        .data_out  (data_out),
        .interrupt (interrupt),
        .rx        (rx),
        .tx        (tx)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (timeout_limit > 0 && cycle_count > timeout_limit)
        begin
            $display("timeout: table not finished after %0d cycles", cycle_count);
            $display("TB FAILED");
            $finish;
        end
    end

    // interrupt activity as a flop sees it
    always @(posedge clk)
    begin
        if (reset && interrupt)
        begin
            irq_cycles++;
            if (!irq_last)
                irq_pulses++;
        end
        irq_last = interrupt;
    end

    // x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return s[0] ? ((s >> 1) ^ 17'h12000) : (s >> 1);
    endfunction

    task automatic random_byte(output byte_t b);
        for (int i = 0; i < 8; i++)
        begin
            lfsr = lfsr_next(lfsr);
            b = {b[6:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string name, input byte_t got, input byte_t exp);
        checks++;
        test_checks++;
        if (got !== exp)
        begin
            $display("Error: %s is 0x%02h, expected 0x%02h", name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        errors++;
        test_errors++;
    endtask

    function automatic void add_row(input int test, input op_t op, input logic en,
                                    input int offset, input src_t src, input byte_t value);
        row_t r;
        r.test  = 3'(test);
        r.op    = op;
        r.en    = en;
        r.addr  = bus_addr_t'(int'(`UART_BASE_ADDR) + offset);
        r.src   = src;
        r.value = value;
        rows.push_back(r);
    endfunction

    function automatic byte_t expected_of(input src_t src, input byte_t lit);
        case (src)
            src_rx_rnd: return rnd_rx;
            src_tx_rnd: return rnd_tx;
            default:    return lit;
        endcase
    endfunction

    task automatic bus_write(input bus_addr_t a, input logic en, input byte_t d);
        @(posedge clk);
        enable   <= en;
        write_en <= 1'b1;
        addr     <= a;
        data_in  <= d;
        @(posedge clk);   // write lands here
        enable   <= 1'b0;
        write_en <= 1'b0;
    endtask

    task automatic bus_read(input bus_addr_t a, input logic en, output byte_t d);
        @(posedge clk);
        enable   <= en;
        write_en <= 1'b0;
        addr     <= a;
        @(negedge clk);
        d = data_out;
        @(posedge clk);
        enable <= 1'b0;
    endtask

    task automatic serial_send(input byte_t b, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, b, 1'b0};
        for (int i = 0; i < 10; i++)
        begin
            @(posedge clk);
            rx <= frame[i];
            repeat (bit_cycles - 1) @(posedge clk);
        end
        @(posedge clk);
        rx <= 1'b1;   // back to idle after a low stop bit
    endtask

    // decodes one frame on tx with mid-bit sampling
    task automatic watch_tx(input byte_t exp);
        byte_t got;
        logic  start_bit;
        logic  stop_bit;
        int    waited;
        waited = 0;
        do
        begin
            @(negedge clk);
            waited++;
        end
        while (tx !== 1'b0 && waited < 2 * bit_cycles);
        if (tx !== 1'b0)
        begin
            report_failure("no start bit on tx within two bit periods");
            return;
        end
        repeat (bit_cycles / 2) @(negedge clk);
        start_bit = tx;
        for (int i = 0; i < 8; i++)
        begin
            repeat (bit_cycles) @(negedge clk);
            got[i] = tx;
        end
        repeat (bit_cycles) @(negedge clk);
        stop_bit = tx;
        check_value("tx start bit", {7'b0, start_bit}, 8'h00);
        check_value("tx data", got, exp);
        check_value("tx stop bit", {7'b0, stop_bit}, 8'h01);
    endtask

    task automatic mark_irq();
        @(negedge clk);
        pulses_before = irq_pulses;
        cycles_before = irq_cycles;
    endtask

    task automatic check_irq(input logic expect_pulse);
        int waited;
        waited = 0;
        do
        begin
            @(negedge clk);
            waited++;
        end
        while (irq_pulses == pulses_before && waited < bit_cycles);
        repeat (2) @(negedge clk);
        check_value("interrupt pulses", byte_t'(irq_pulses - pulses_before), {7'b0, expect_pulse});
        check_value("interrupt cycles", byte_t'(irq_cycles - cycles_before), {7'b0, expect_pulse});
    endtask

    task automatic run_transmit(input logic with_rx);
        byte_t cmd;
        int    tries;
        mark_irq();
        fork
            watch_tx(rnd_tx);
            if (with_rx)
                serial_send(rnd_rx, 1'b1);
            begin
                repeat (5 * bit_cycles) @(posedge clk);   // well inside the frame
                bus_read(base_addr, 1'b1, cmd);
                check_value("tx_cmd in frame", cmd, 8'h00);
            end
        join
        tries = 0;
        do
        begin
            bus_read(base_addr, 1'b1, cmd);
            tries++;
        end
        while (cmd !== 8'h01 && tries < bit_cycles);
        check_value("tx_cmd after frame", cmd, 8'h01);
        if (with_rx)
            check_irq(1'b1);
    endtask

    function automatic void build_table();
        add_row(1, op_idle, 1'b1, 0, src_lit, 0);
        add_row(1, op_read, 1'b1, 0, src_lit, 8'h01);
        add_row(1, op_read, 1'b1, 1, src_lit, 0);
        add_row(1, op_read, 1'b1, 2, src_lit, 0);
        add_row(1, op_read, 1'b1, 3, src_lit, 0);
        add_row(2, op_write, 1'b1, 1, src_tx_rnd, 0);
        add_row(2, op_read, 1'b1, 1, src_tx_rnd, 0);
        add_row(2, op_write, 1'b1, 0, src_lit, 0);
        add_row(2, op_expect_tx, 1'b1, 0, src_tx_rnd, 0);
        add_row(3, op_send, 1'b1, 0, src_rx_rnd, 0);
        add_row(3, op_read, 1'b1, 3, src_rx_rnd, 0);
        add_row(3, op_read, 1'b1, 2, src_lit, 1);
        add_row(3, op_write, 1'b1, 2, src_lit, 0);
        add_row(3, op_read, 1'b1, 2, src_lit, 0);
        // misses below, above and with enable low
        add_row(4, op_write, 1'b1, -3, src_lit, 8'h5a);
        add_row(4, op_write, 1'b1, 4, src_lit, 8'h00);
        add_row(4, op_write, 1'b0, 0, src_lit, 8'h00);
        add_row(4, op_write, 1'b0, 1, src_lit, 8'hc3);
        add_row(4, op_write, 1'b0, 2, src_lit, 8'h01);
        add_row(4, op_read, 1'b1, -1, src_lit, 0);
        add_row(4, op_read, 1'b1, 4, src_lit, 0);
        add_row(4, op_read, 1'b0, 3, src_lit, 0);
        add_row(4, op_read, 1'b1, 0, src_lit, 1);
        add_row(4, op_read, 1'b1, 1, src_tx_rnd, 0);
        add_row(4, op_read, 1'b1, 2, src_lit, 0);
        add_row(4, op_read, 1'b1, 3, src_rx_rnd, 0);
        add_row(4, op_idle, 1'b1, 0, src_lit, 0);
        add_row(5, op_write, 1'b1, 1, src_tx_rnd, 0);
        add_row(5, op_write, 1'b1, 0, src_lit, 0);
        add_row(5, op_duplex, 1'b1, 0, src_tx_rnd, 0);
        add_row(5, op_read, 1'b1, 3, src_rx_rnd, 0);
        add_row(5, op_send, 1'b1, 0, src_rx_rnd, 0);   // status left set
        add_row(5, op_read, 1'b1, 3, src_rx_rnd, 0);
        add_row(5, op_read, 1'b1, 2, src_lit, 1);
        add_row(6, op_write, 1'b1, 2, src_lit, 0);
        add_row(6, op_send_bad, 1'b1, 0, src_lit, 8'h3c);
        add_row(6, op_read, 1'b1, 2, src_lit, 0);
        add_row(6, op_read, 1'b1, 3, src_rx_rnd, 0);
    endfunction

    task automatic finish_test(input int id);
        $display("test %0d %s: %0d checks, %0d errors",
                 id, test_names[id - 1], test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    initial
    begin
        row_t  r;
        byte_t got;
        int    cur_test;
        int    serial_rows;
        int    bus_rows;
        reset    <= 1'b0;
        enable   <= 1'b0;
        write_en <= 1'b0;
        addr     <= '0;
        data_in  <= '0;
        rx       <= 1'b1;
        build_table();
        serial_rows = 0;
        bus_rows = 0;
        foreach (rows[i])
        begin
            if (rows[i].op inside {op_send, op_send_bad, op_expect_tx, op_duplex})
                serial_rows++;
            else
                bus_rows++;
        end
        timeout_limit = serial_rows * 12 * bit_cycles + bus_rows * 4 + 2 * bit_cycles;
        repeat (2) @(posedge clk);
        reset <= 1'b1;
        cur_test = 1;
        for (int i = 0; i < rows.size(); i++)
        begin
            r = rows[i];
            if (int'(r.test) != cur_test)
            begin
                finish_test(cur_test);
                cur_test = int'(r.test);
            end
            case (r.op)
                op_idle:
                begin
                    @(negedge clk);
                    check_value("tx", {7'b0, tx}, 8'h01);
                    check_value("interrupt", {7'b0, interrupt}, 8'h00);
                end
                op_write:
                begin
                    if (r.src == src_tx_rnd)
                        random_byte(rnd_tx);
                    bus_write(r.addr, r.en, expected_of(r.src, r.value));
                end
                op_read:
                begin
                    bus_read(r.addr, r.en, got);
                    check_value($sformatf("data_out at %04h", r.addr), got,
                                expected_of(r.src, r.value));
                end
                op_send, op_send_bad:
                begin
                    if (r.src == src_rx_rnd)
                        random_byte(rnd_rx);
                    mark_irq();
                    serial_send(expected_of(r.src, r.value), r.op == op_send);
                    check_irq(r.op == op_send);
                end
                op_expect_tx:
                    run_transmit(1'b0);
                op_duplex:
                begin
                    random_byte(rnd_rx);
                    run_transmit(1'b1);
                end
                default:
                    report_failure("unknown operation in the stimulus table");
            endcase
        end
        finish_test(cur_test);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+hw
hw/uart_pkg.sv
hw/baud_tick_gen.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_regs.sv
hw/uart_periph.sv
dv/uart_assertions.sv
dv/uart_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the UART testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module uart_tb \
    -o uart_sim

./obj_dir/uart_sim > sim.log 2>&1
cat sim.log

if grep -q "TB FAILED" sim.log; then
    echo "simulation reported failures, see sim.log"
    exit 1
fi

echo "simulation finished without failures"
